/* verilog/periph_pkg.sv */
package periph_pkg;

    // register word and addressing.
    typedef logic [15:0] data_t;
    typedef logic [2:0]  reg_addr_t;
    // one strobe bit per register.
    typedef logic [7:0]  reg_sel_t;
    typedef logic [3:0]  prio_t;

    // register map.
    localparam reg_addr_t REG_LEDS       = 3'd0;
    localparam reg_addr_t REG_KEYS       = 3'd1;
    localparam reg_addr_t REG_USTIMER    = 3'd2;
    localparam reg_addr_t REG_MSTIMER    = 3'd3;
    localparam reg_addr_t REG_PWM_DUTY   = 3'd4;
    localparam reg_addr_t REG_EVENT_MASK = 3'd5;
    localparam reg_addr_t REG_EVENT_PRIO = 3'd6;
    localparam reg_addr_t REG_SOFT_EVENT = 3'd7;

    // timing. sysclk is 50 MHz, so 50 cycles make one microsecond.
    localparam int US_DIV     = 50;
    localparam int MS_DIV     = 1000;
    // 50 us period gives a 20 kHz relay drive.
    localparam int PWM_PERIOD = 50;
    localparam int PWM_WIDTH  = 6;

    // divider and duty vectors sized from the constants above.
    typedef logic [$clog2(US_DIV)-1:0] us_cnt_t;
    typedef logic [$clog2(MS_DIV)-1:0] ms_cnt_t;
    typedef logic [PWM_WIDTH-1:0]      duty_t;

    // event indices, most urgent first.
    localparam int EV_POWER_LOST = 0;
    localparam int EV_USTIMER    = 1;
    localparam int EV_MSTIMER    = 2;
    localparam int EV_KEY0       = 3;
    localparam int EV_KEY1       = 4;
    localparam int EV_SOFT0      = 5;
    localparam int EV_SOFT1      = 6;
    localparam int EV_SOFT2      = 7;
    localparam int EV_SOFT3      = 8;
    localparam int NUM_EVENTS    = 9;
    // reported when nothing is pending.
    localparam prio_t EVENT_NONE = 4'd15;

    // register decoder states.
    typedef enum logic {
        IDLE,
        ACK
    } dec_state_t;

endpackage

/* verilog/reg_bus_if.sv */
`timescale 1ns/10ps

// strobe bus between the register decoder and the peripherals.
interface reg_bus_if;
    import periph_pkg::*;

    // one bit pulses for one cycle on an acknowledged write.
    reg_sel_t load;
    // one bit pulses for one cycle on an acknowledged read.
    reg_sel_t read;
    // write data, shared by every register.
    data_t    load_data;

    // the decoder drives everything.
    modport master (
        output load,
        output read,
        output load_data
    );

    // peripherals only listen.
    modport slave (
        input load,
        input read,
        input load_data
    );

endinterface

/* verilog/wb_reg_decoder.sv */
`timescale 1ns/10ps

module wb_reg_decoder (
    input  logic                  sysclk,
    input  logic                  arst_n,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  periph_pkg::reg_addr_t wb_adr,
    input  periph_pkg::data_t     wb_dat_i,
    output periph_pkg::data_t     wb_dat_o,
    output logic                  wb_ack,
    reg_bus_if.master             bus,
    input  periph_pkg::data_t     rd_values [8]
);
    import periph_pkg::*;

    dec_state_t state;

    // two clocks per bus cycle, so no wait states are ever needed.
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (wb_cyc && wb_stb) begin
                        state <= ACK;
                    end
                end
                ACK: begin
                    // master drops or re-presents after seeing ack.
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // read data is captured in idle so it is valid with ack.
    always_ff @(posedge sysclk) begin
        if (state == IDLE && wb_cyc && wb_stb) begin
            wb_dat_o <= rd_values[wb_adr];
        end
    end

    assign wb_ack = (state == ACK);

    // master holds its inputs until ack, so they are still valid here.
    always_comb begin
        bus.load = '0;
        bus.read = '0;
        if (state == ACK) begin
            if (wb_we) begin
                bus.load[wb_adr] = 1'b1;
            end else begin
                bus.read[wb_adr] = 1'b1;
            end
        end
    end

    // target register takes this word on the edge that ends the ack cycle.
    assign bus.load_data = wb_dat_i;

endmodule

/* verilog/tick_gen.sv */
`timescale 1ns/10ps

module tick_gen (
    input  logic sysclk,
    input  logic arst_n,
    input  logic halt,
    output logic us_tick,
    output logic ms_tick
);
    import periph_pkg::*;

    us_cnt_t us_cnt;
    ms_cnt_t ms_cnt;

    // strobes are gated by halt so time stands still while halted.
    assign us_tick = !halt && (us_cnt == us_cnt_t'(US_DIV - 1));
    assign ms_tick = us_tick && (ms_cnt == ms_cnt_t'(MS_DIV - 1));

    // sysclk divider.
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            us_cnt <= '0;
        end else if (!halt) begin
            us_cnt <= us_tick ? '0 : us_cnt + 1'b1;
        end
    end

    // microsecond divider, it only moves on a us strobe.
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            ms_cnt <= '0;
        end else if (us_tick) begin
            ms_cnt <= ms_tick ? '0 : ms_cnt + 1'b1;
        end
    end

endmodule

/* verilog/cd_timer.sv */
`timescale 1ns/10ps

module cd_timer #(
    // selects which load strobe belongs to this timer.
    parameter periph_pkg::reg_addr_t REG_ADDR = periph_pkg::REG_USTIMER
) (
    input  logic              sysclk,
    input  logic              arst_n,
    reg_bus_if.slave          bus,
    input  logic              tick,
    output periph_pkg::data_t value,
    output logic              expired
);
    import periph_pkg::*;

    data_t count;

    // a write wins over a tick in the same cycle.
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (bus.load[REG_ADDR]) begin
            count <= bus.load_data;
        end else if (tick && count != '0) begin
            // stops at zero, no wrap.
            count <= count - 1'b1;
        end
    end

    assign value = count;

    // zero after reset, so a fresh timer reads as expired.
    assign expired = (count == '0);

endmodule

/* verilog/cd_pwm.sv */
`timescale 1ns/10ps

module cd_pwm (
    input  logic              sysclk,
    input  logic              arst_n,
    reg_bus_if.slave          bus,
    input  logic              us_tick,
    output periph_pkg::data_t duty,
    output logic              pwm_out
);
    import periph_pkg::*;

    duty_t duty_q;
    duty_t period_cnt;

    // only the low bits of the word are kept.
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            duty_q <= '0;
        end else if (bus.load[REG_PWM_DUTY]) begin
            duty_q <= bus.load_data[PWM_WIDTH-1:0];
        end
    end

    // counts PWM_PERIOD down to 1, one step per microsecond.
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            period_cnt <= duty_t'(PWM_PERIOD);
        end else if (us_tick) begin
            period_cnt <= (period_cnt == duty_t'(1)) ? duty_t'(PWM_PERIOD) : period_cnt - 1'b1;
        end
    end

    // counter never reaches 0, so duty 0 stays low.
    // duty at PWM_PERIOD or above stays high.
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            pwm_out <= 1'b0;
        end else begin
            pwm_out <= (period_cnt <= duty_q);
        end
    end

    assign duty = data_t'(duty_q);

endmodule

/* verilog/event_controller.sv */
`timescale 1ns/10ps

module event_controller (
    input  logic              sysclk,
    input  logic              arst_n,
    reg_bus_if.slave          bus,
    input  logic              power_lost,
    input  logic              ustimer_expired,
    input  logic              mstimer_expired,
    input  logic [1:0]        key,
    output periph_pkg::data_t mask_value,
    output periph_pkg::data_t soft_value,
    output periph_pkg::data_t prio
);
    import periph_pkg::*;

    // {key, power_lost} through two flops.
    logic [2:0]                    sync_1;
    logic [2:0]                    sync_2;
    data_t                         mask_q;
    logic [NUM_EVENTS-EV_SOFT0-1:0] soft_q;
    logic [NUM_EVENTS-1:0]         events;
    logic [NUM_EVENTS-1:0]         pending;
    prio_t                         prio_next;
    prio_t                         prio_q;
    logic [1:0]                    soft_idx;

    // idle values are keys released, power present.
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            sync_1 <= 3'b110;
            sync_2 <= 3'b110;
        end else begin
            sync_1 <= {key, power_lost};
            sync_2 <= sync_1;
        end
    end

    // keys are active low.
    assign events[EV_POWER_LOST]     = sync_2[0];
    assign events[EV_USTIMER]        = ustimer_expired;
    assign events[EV_MSTIMER]        = mstimer_expired;
    assign events[EV_KEY0]           = !sync_2[1];
    assign events[EV_KEY1]           = !sync_2[2];
    assign events[EV_SOFT3:EV_SOFT0] = soft_q;

    assign pending  = events & mask_q[NUM_EVENTS-1:0];
    assign soft_idx = 2'(prio_q - prio_t'(EV_SOFT0));

    // lowest pending index wins.
    always_comb begin
        prio_next = EVENT_NONE;
        for (int i = NUM_EVENTS - 1; i >= 0; i--) begin
            if (pending[i]) begin
                prio_next = prio_t'(i);
            end
        end
    end

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            mask_q <= '0;
            soft_q <= '0;
            prio_q <= EVENT_NONE;
        end else begin
            prio_q <= prio_next;
            if (bus.load[REG_EVENT_MASK]) begin
                mask_q <= bus.load_data;
            end
            if (bus.load[REG_SOFT_EVENT]) begin
                soft_q <= bus.load_data[NUM_EVENTS-EV_SOFT0-1:0];
            end else if (bus.read[REG_EVENT_PRIO] && prio_q >= prio_t'(EV_SOFT0) &&
                         prio_q < prio_t'(NUM_EVENTS)) begin
                // reading a soft event's priority acknowledges it.
                soft_q[soft_idx] <= 1'b0;
            end
        end
    end

    assign mask_value = mask_q;
    assign soft_value = data_t'(soft_q);
    assign prio       = data_t'(prio_q);

endmodule

/* verilog/periph_top.sv */
`timescale 1ns/10ps

module periph_top (
    input  logic                  sysclk,
    input  logic                  arst_n,
    input  logic                  halt,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  periph_pkg::reg_addr_t wb_adr,
    input  periph_pkg::data_t     wb_dat_i,
    output periph_pkg::data_t     wb_dat_o,
    output logic                  wb_ack,
    input  logic [1:0]            key,
    input  logic                  power_lost,
    output logic [7:0]            led,
    output logic                  pwm_out
);
    import periph_pkg::*;

    logic  us_tick;
    logic  ms_tick;
    logic  ustimer_expired;
    logic  mstimer_expired;
    logic [7:0] led_q;
    data_t rd_values [8];

    reg_bus_if bus ();

    wb_reg_decoder u_decoder (
        .sysclk    (sysclk),
        .arst_n    (arst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_i  (wb_dat_i),
        .wb_dat_o  (wb_dat_o),
        .wb_ack    (wb_ack),
        .bus       (bus.master),
        .rd_values (rd_values)
    );

    // halt stops every timebase below.
    tick_gen u_ticks (
        .sysclk  (sysclk),
        .arst_n  (arst_n),
        .halt    (halt),
        .us_tick (us_tick),
        .ms_tick (ms_tick)
    );

    // microsecond timer.
    cd_timer #(.REG_ADDR(REG_USTIMER)) u_ustimer (
        .sysclk  (sysclk),
        .arst_n  (arst_n),
        .bus     (bus.slave),
        .tick    (us_tick),
        .value   (rd_values[REG_USTIMER]),
        .expired (ustimer_expired)
    );

    // millisecond timer.
    cd_timer #(.REG_ADDR(REG_MSTIMER)) u_mstimer (
        .sysclk  (sysclk),
        .arst_n  (arst_n),
        .bus     (bus.slave),
        .tick    (ms_tick),
        .value   (rd_values[REG_MSTIMER]),
        .expired (mstimer_expired)
    );

    // power relay drive.
    cd_pwm u_pwm (
        .sysclk  (sysclk),
        .arst_n  (arst_n),
        .bus     (bus.slave),
        .us_tick (us_tick),
        .duty    (rd_values[REG_PWM_DUTY]),
        .pwm_out (pwm_out)
    );

    event_controller u_events (
        .sysclk          (sysclk),
        .arst_n          (arst_n),
        .bus             (bus.slave),
        .power_lost      (power_lost),
        .ustimer_expired (ustimer_expired),
        .mstimer_expired (mstimer_expired),
        .key             (key),
        .mask_value      (rd_values[REG_EVENT_MASK]),
        .soft_value      (rd_values[REG_SOFT_EVENT]),
        .prio            (rd_values[REG_EVENT_PRIO])
    );

    // the LED register is the only state held at this level.
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            led_q <= '0;
        end else if (bus.load[REG_LEDS]) begin
            led_q <= bus.load_data[7:0];
        end
    end

    assign led = led_q;
    assign rd_values[REG_LEDS] = data_t'(led_q);
    // raw pins, not synchronized.
    assign rd_values[REG_KEYS] = data_t'(key);

endmodule

/* dv/periph_chk.sv */
`timescale 1ns/10ps

module periph_chk (
    input logic sysclk,
    input logic arst_n,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack
);

    // a classic cycle gets exactly one ack.
    ack_single: assert property (@(posedge sysclk) disable iff (!arst_n)
        wb_ack |=> !wb_ack)
        else $error("wb_ack high for two cycles in a row");

    // ack answers a request seen on the edge before.
    ack_after_req: assert property (@(posedge sysclk) disable iff (!arst_n)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else $error("wb_ack without a preceding cyc and stb");

    // the decoder sits in idle while reset is held.
    ack_in_reset: assert property (@(posedge sysclk)
        !arst_n |-> !wb_ack)
        else $error("wb_ack high during reset");

endmodule

bind periph_top periph_chk u_chk (
    .sysclk (sysclk),
    .arst_n (arst_n),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_ack (wb_ack)
);

/* dv/tb_periph.sv */
`timescale 1ns/10ps

module tb_periph;
    import periph_pkg::*;

    // row kinds of the stimulus table.
    typedef enum int {
        OP_WRITE,
        OP_READ,
        OP_WAIT,
        OP_SET,
        OP_PINS,
        OP_PWM
    } op_t;

    // wait and pwm rows keep microseconds in data.
    // pwm rows keep their tolerance in microseconds in addr.
    typedef struct {
        op_t op;
        int  addr;
        int  data;
        int  expected;
        int  test;
    } row_t;

    // pins a set row can drive, picked by addr.
    localparam int PIN_KEY   = 0;
    localparam int PIN_POWER = 1;
    localparam int PIN_HALT  = 2;
    localparam int NUM_TESTS = 5;

    logic       sysclk;
    logic       arst_n;
    logic       halt;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    reg_addr_t  wb_adr;
    data_t      wb_dat_i;
    data_t      wb_dat_o;
    logic       wb_ack;
    logic [1:0] key;
    logic       power_lost;
    logic [7:0] led;
    logic       pwm_out;

    row_t  rows[$];
    string test_names[NUM_TESTS] = '{"reset", "regs", "ustimer", "pwm", "events"};
    string reg_names[8] = '{"leds", "keys", "ustimer", "mstimer",
                            "pwm_duty", "event_mask", "event_prio", "soft_event"};
    int    cycles;
    int    limit;
    int    errors;
    int    test_errors;
    int    tests_failed;

    periph_top DUT (.*);

    always #2 sysclk = ~sysclk;

    // watchdog, limit is set once the table exists.
    always @(posedge sysclk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout after %0d cycles, a bus cycle or wait never ended", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic add_row(input op_t op, input int addr, input int data,
                           input int expected, input int test);
        rows.push_back(row_t'{op, addr, data, expected, test});
    endtask

    task automatic build_table();
        // reset values.
        add_row(OP_READ, REG_LEDS, 0, 0, 0);
        add_row(OP_READ, REG_USTIMER, 0, 0, 0);
        add_row(OP_READ, REG_MSTIMER, 0, 0, 0);
        add_row(OP_READ, REG_EVENT_PRIO, 0, EVENT_NONE, 0);
        add_row(OP_PINS, 0, 0, 0, 0);
        // write and read back, led pins carry the low byte.
        add_row(OP_WRITE, REG_LEDS, 'h00c3, 0, 1);
        add_row(OP_READ, REG_LEDS, 0, 'h00c3, 1);
        add_row(OP_PINS, 0, 0, 'h0c3, 1);
        add_row(OP_WRITE, REG_PWM_DUTY, 'h0015, 0, 1);
        add_row(OP_READ, REG_PWM_DUTY, 0, 'h0015, 1);
        add_row(OP_WRITE, REG_EVENT_MASK, 'h01a5, 0, 1);
        add_row(OP_READ, REG_EVENT_MASK, 0, 'h01a5, 1);
        add_row(OP_SET, PIN_KEY, 'b10, 0, 1);
        add_row(OP_READ, REG_KEYS, 0, 'h0002, 1);
        add_row(OP_SET, PIN_KEY, 'b11, 0, 1);
        // microsecond timer runs out, then stands still in halt.
        add_row(OP_WRITE, REG_USTIMER, 5, 0, 2);
        add_row(OP_WAIT, 0, 7, 0, 2);
        add_row(OP_READ, REG_USTIMER, 0, 0, 2);
        add_row(OP_WRITE, REG_EVENT_MASK, 1 << EV_USTIMER, 0, 2);
        add_row(OP_READ, REG_EVENT_PRIO, 0, EV_USTIMER, 2);
        add_row(OP_SET, PIN_HALT, 1, 0, 2);
        add_row(OP_WRITE, REG_USTIMER, 100, 0, 2);
        add_row(OP_WAIT, 0, 10, 0, 2);
        add_row(OP_READ, REG_USTIMER, 0, 100, 2);
        add_row(OP_SET, PIN_HALT, 0, 0, 2);
        // high time per period equals the duty in microseconds.
        add_row(OP_WRITE, REG_PWM_DUTY, 0, 0, 3);
        add_row(OP_PWM, 0, PWM_PERIOD, 0, 3);
        add_row(OP_WRITE, REG_PWM_DUTY, 63, 0, 3);
        add_row(OP_PWM, 0, PWM_PERIOD, PWM_PERIOD, 3);
        add_row(OP_WRITE, REG_PWM_DUTY, 25, 0, 3);
        add_row(OP_PWM, 1, PWM_PERIOD, 25, 3);
        // timers loaded so they stay quiet, soft events pending.
        add_row(OP_WRITE, REG_USTIMER, 1000, 0, 4);
        add_row(OP_WRITE, REG_MSTIMER, 100, 0, 4);
        add_row(OP_WRITE, REG_SOFT_EVENT, 'h000f, 0, 4);
        add_row(OP_WRITE, REG_EVENT_MASK, 'h01ff, 0, 4);
        add_row(OP_READ, REG_EVENT_PRIO, 0, EV_SOFT0, 4);
        add_row(OP_WRITE, REG_EVENT_MASK, 'h01df, 0, 4);
        // soft event 5 pending again, only the mask hides it.
        add_row(OP_WRITE, REG_SOFT_EVENT, 'h000f, 0, 4);
        add_row(OP_READ, REG_EVENT_PRIO, 0, EV_SOFT1, 4);
        add_row(OP_SET, PIN_POWER, 1, 0, 4);
        add_row(OP_WAIT, 0, 1, 0, 4);
        add_row(OP_READ, REG_EVENT_PRIO, 0, EV_POWER_LOST, 4);
        add_row(OP_SET, PIN_POWER, 0, 0, 4);
        add_row(OP_SET, PIN_KEY, 'b10, 0, 4);
        add_row(OP_WRITE, REG_EVENT_MASK, 'h01f8, 0, 4);
        add_row(OP_WAIT, 0, 1, 0, 4);
        add_row(OP_READ, REG_EVENT_PRIO, 0, EV_KEY0, 4);
        add_row(OP_SET, PIN_KEY, 'b11, 0, 4);
    endtask

    // reset, every wait, and 20 cycles of slack per row.
    function automatic int timeout_limit();
        int total;
        total = 3;
        foreach (rows[i]) begin
            if (rows[i].op == OP_WAIT || rows[i].op == OP_PWM) begin
                total += rows[i].data * US_DIV;
            end
            total += 20;
        end
        return total;
    endfunction

    // one classic cycle, inputs held until ack.
    task automatic bus_cycle(input logic we, input int addr, input int data,
                             output data_t rdata);
        @(posedge sysclk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= reg_addr_t'(addr);
        wb_dat_i <= data_t'(data);
        // ack and read data are settled by the falling edge.
        do begin
            @(negedge sysclk);
        end while (!wb_ack);
        rdata = wb_dat_o;
        @(posedge sysclk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic check_value(input string name, input int got, input int expected);
        assert (got == expected) else begin
            $display("Mismatch at %0t: %s got 'h%0h expected 'h%0h",
                     $time, name, got, expected);
            test_errors++;
        end
    endtask

    // pwm_out sampled once per sysclk.
    task automatic measure_pwm(input int us, output int high_cycles);
        high_cycles = 0;
        // the registered output picks up a new duty one edge after the load.
        @(posedge sysclk);
        repeat (us * US_DIV) begin
            @(negedge sysclk);
            if (pwm_out) begin
                high_cycles++;
            end
        end
    endtask

    task automatic apply_row(input row_t row);
        data_t rdata;
        int    high_cycles;
        case (row.op)
            OP_WRITE: begin
                bus_cycle(1'b1, row.addr, row.data, rdata);
            end
            OP_READ: begin
                bus_cycle(1'b0, row.addr, 0, rdata);
                check_value(reg_names[row.addr], int'(rdata), row.expected);
            end
            OP_WAIT: begin
                repeat (row.data * US_DIV) @(posedge sysclk);
            end
            OP_SET: begin
                @(posedge sysclk);
                case (row.addr)
                    PIN_KEY:   key <= 2'(row.data);
                    PIN_POWER: power_lost <= row.data[0];
                    default:   halt <= row.data[0];
                endcase
            end
            OP_PINS: begin
                @(negedge sysclk);
                check_value("{pwm_out, led}", int'({pwm_out, led}), row.expected);
            end
            default: begin
                measure_pwm(row.data, high_cycles);
                // tolerance in microseconds comes from addr.
                assert (high_cycles >= (row.expected - row.addr) * US_DIV &&
                        high_cycles <= (row.expected + row.addr) * US_DIV) else begin
                    $display("Mismatch at %0t: pwm_out high cycles got %0d expected %0d",
                             $time, high_cycles, row.expected * US_DIV);
                    test_errors++;
                end
            end
        endcase
    endtask

    task automatic finish_test(input int test);
        if (test_errors == 0) begin
            $display("test %0d %s: pass", test, test_names[test]);
        end else begin
            $display("test %0d %s: fail, %0d errors", test, test_names[test], test_errors);
            tests_failed++;
        end
        errors += test_errors;
        test_errors = 0;
    endtask

    initial begin
        sysclk       = 1'b0;
        arst_n       = 1'b0;
        halt         = 1'b0;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_i     = '0;
        key          = 2'b11;
        power_lost   = 1'b0;
        cycles       = 0;
        errors       = 0;
        test_errors  = 0;
        tests_failed = 0;
        build_table();
        limit = timeout_limit();
        repeat (3) @(posedge sysclk);
        arst_n <= 1'b1;
        foreach (rows[i]) begin
            apply_row(rows[i]);
            if (i == rows.size() - 1 || rows[i + 1].test != rows[i].test) begin
                finish_test(rows[i].test);
            end
        end
        $display("summary: %0d tests, %0d failed, %0d errors in %0d cycles",
                 NUM_TESTS, tests_failed, errors, cycles);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* all.f */
verilog/periph_pkg.sv
verilog/reg_bus_if.sv
verilog/wb_reg_decoder.sv
verilog/tick_gen.sv
verilog/cd_timer.sv
verilog/cd_pwm.sv
verilog/event_controller.sv
verilog/periph_top.sv
dv/periph_chk.sv
dv/tb_periph.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the peripheral testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_periph \
    -f all.f -o sim_periph > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_periph 2>&1 | tee sim.log
grep -qx "NO ERRORS" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
